/* run.sh */
#!/bin/sh
# build the icache testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
  -f src.f -o icache_sim > build.log 2>&1 \
  || { echo "verilator build failed, see build.log"; exit 1; }

./obj_dir/icache_sim > sim.log 2>&1
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"

/* source/icache_ctrl.sv */
`timescale 1ns/100ps

module icache_ctrl import icache_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  // fetch request, held until accepted
  input  logic            fetch_valid_i,
  input  fetch_addr_u     fetch_addr_i,
  output logic            fetch_ready_o,
  output logic            rdata_valid_o,
  output logic [XLEN-1:0] rdata_o,
  // store results, one cycle after the address
  input  logic            hit_i,
  input  logic [XLEN-1:0] line_word_i,
  // memory reader status
  input  logic            refill_done_i,
  input  logic            uncached_done_i,
  input  logic [XLEN-1:0] uncached_word_i,
  // store address and refill control
  output fetch_addr_u     lookup_addr_o,
  output logic            tag_write_o,
  output logic            start_refill_o,
  output logic            start_uncached_o,
  output logic [XLEN-1:0] req_addr_o
);

  ctrl_state_e     state_q;
  ctrl_state_e     state_d;
  fetch_addr_u     req_q;
  logic            accept;
  logic            is_uncached;
  logic            lookup_hit;
  logic            rdata_valid_q;
  logic [XLEN-1:0] rdata_q;

  // request taken only while idle
  assign fetch_ready_o = (state_q == IDLE);
  assign accept        = fetch_valid_i && fetch_ready_o;

  // uncached window test on the captured address
  assign is_uncached = (req_q.raw & UNCACHE_MASK) == UNCACHE_BASE;

  // uncached wins over any stale hit
  assign lookup_hit = (state_q == LOOKUP) && !is_uncached && hit_i;

  // stores see the live address on accept, the held one otherwise
  // replay re-presents the held address after the refill
  assign lookup_addr_o = (state_q == IDLE) ? fetch_addr_i : req_q;

  // one-cycle start pulses, issued from lookup
  assign start_refill_o   = (state_q == LOOKUP) && !is_uncached && !hit_i;
  assign start_uncached_o = (state_q == LOOKUP) && is_uncached;

  // tag goes valid together with the refill done pulse
  assign tag_write_o = (state_q == MISS) && refill_done_i;

  // line address for a burst, word address for a single read
  assign req_addr_o = is_uncached ? {req_q.raw[XLEN-1:2], 2'b00}
                                  : {req_q.raw[XLEN-1:OFFSET_W], {OFFSET_W{1'b0}}};

  always_comb begin
    state_d = state_q;
    case (state_q)
      RST: state_d = IDLE;
      IDLE: begin
        if (fetch_valid_i) begin
          state_d = LOOKUP;
        end
      end
      LOOKUP: begin
        if (is_uncached) begin
          state_d = UNCACHED;
        end else if (hit_i) begin
          state_d = DONE;
        end else begin
          state_d = MISS;
        end
      end
      // wait for the last burst beat
      MISS: begin
        if (refill_done_i) begin
          state_d = REPLAY;
        end
      end
      UNCACHED: begin
        if (uncached_done_i) begin
          state_d = DONE;
        end
      end
      REPLAY: state_d = LOOKUP;
      // valid pulse cycle
      DONE: state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q       <= RST;
      rdata_valid_q <= 1'b0;
    end else begin
      state_q       <= state_d;
      // single pulse, raised by a hit or the uncached beat
      rdata_valid_q <= lookup_hit || ((state_q == UNCACHED) && uncached_done_i);
    end
  end

  // request address and returned word
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q <= fetch_addr_i;
    end
    if (lookup_hit) begin
      rdata_q <= line_word_i;
    end else if ((state_q == UNCACHED) && uncached_done_i) begin
      rdata_q <= uncached_word_i;
    end
  end

  assign rdata_valid_o = rdata_valid_q;
  assign rdata_o       = rdata_q;

endmodule

/* source/icache_data_store.sv */
`timescale 1ns/100ps

module icache_data_store import icache_pkg::*; #(
  parameter int LINE_WORDS = icache_pkg::LINE_WORDS,
  parameter int SETS       = icache_pkg::SETS
) (
  input  logic               clk,
  // lookup read
  input  fetch_addr_u        rd_addr_i,
  // refill write, one word per beat
  input  logic               wr_i,
  input  logic [INDEX_W-1:0] wr_index_i,
  input  logic [BEAT_W-1:0]  wr_word_i,
  input  logic [XLEN-1:0]    wr_data_i,
  output logic [XLEN-1:0]    rd_data_o
);

  localparam int IDX_B  = $clog2(SETS);
  localparam int WORD_B = $clog2(LINE_WORDS);
  localparam int PTR_W  = IDX_B + WORD_B;

  // flat word array, line index above word position
  logic [XLEN-1:0]  data_mem [SETS*LINE_WORDS];
  logic [XLEN-1:0]  rd_q;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr;

  assign rd_ptr = {rd_addr_i.f.index[IDX_B-1:0], rd_addr_i.f.word[WORD_B-1:0]};

  // beat index is the word position
  assign wr_ptr = {wr_index_i[IDX_B-1:0], wr_word_i[WORD_B-1:0]};

  always_ff @(posedge clk) begin
    if (wr_i) begin
      data_mem[wr_ptr] <= wr_data_i;
    end
    // synchronous read, result in the next cycle
    rd_q <= data_mem[rd_ptr];
  end

  assign rd_data_o = rd_q;

endmodule

/* source/icache_pkg.sv */
package icache_pkg;

  // bus and address widths
  localparam int XLEN = 32;

  // address split into tag, index and offset
  localparam int TAG_W    = 19;
  localparam int INDEX_W  = 7;
  localparam int OFFSET_W = 6;

  // cache geometry, 128 lines of 16 words
  localparam int LINE_WORDS = 16;
  localparam int SETS       = 128;

  // beat counter covers one full line burst
  localparam int BEAT_W = 4;

  // uncached window 0x1000_0000 .. 0x1fff_ffff
  localparam logic [XLEN-1:0] UNCACHE_BASE = 32'h1000_0000;
  localparam logic [XLEN-1:0] UNCACHE_MASK = 32'hf000_0000;

  // fetch address as split fields
  typedef struct packed {
    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    // word within the line
    logic [BEAT_W-1:0]  word;
    // byte within the word, ignored on fetch
    logic [1:0]         byte_off;
  } fetch_fields_t;

  // same 32 bits seen raw or as fields
  typedef union packed {
    logic [XLEN-1:0] raw;
    fetch_fields_t   f;
  } fetch_addr_u;

  // controller states
  typedef enum logic [2:0] {
    RST,
    IDLE,
    LOOKUP,
    MISS,
    UNCACHED,
    REPLAY,
    DONE
  } ctrl_state_e;

endpackage

/* source/icache_tag_store.sv */
`timescale 1ns/100ps

module icache_tag_store import icache_pkg::*; #(
  parameter int SETS = icache_pkg::SETS
) (
  input  logic        clk,
  input  logic        rst,
  input  fetch_addr_u rd_addr_i,
  input  logic        wr_i,
  output logic        hit_o
);

  // index bits used for the set, the rest joins the tag
  localparam int IDX_B  = $clog2(SETS);
  localparam int LINE_W = TAG_W + INDEX_W;
  localparam int KEY_W  = LINE_W - IDX_B;

  logic [KEY_W-1:0]  tag_mem [SETS];
  logic [SETS-1:0]   valid_q;

  // read side, registered
  fetch_addr_u       rd_q;
  logic [KEY_W-1:0]  tag_q;
  logic              valid_bit_q;

  logic [LINE_W-1:0] rd_line;
  logic [IDX_B-1:0]  rd_set;
  logic [LINE_W-1:0] q_line;
  logic [IDX_B-1:0]  q_set;
  logic [KEY_W-1:0]  q_key;

  assign rd_line = {rd_addr_i.f.tag, rd_addr_i.f.index};
  assign rd_set  = rd_line[IDX_B-1:0];

  // captured address, also the write target
  assign q_line = {rd_q.f.tag, rd_q.f.index};
  assign q_set  = q_line[IDX_B-1:0];
  assign q_key  = q_line[LINE_W-1:IDX_B];

  always_ff @(posedge clk) begin
    rd_q  <= rd_addr_i;
    tag_q <= tag_mem[rd_set];
    if (wr_i) begin
      tag_mem[q_set] <= q_key;
    end
  end

  // valid bits cleared on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q     <= '0;
      valid_bit_q <= 1'b0;
    end else begin
      valid_bit_q <= valid_q[rd_set];
      if (wr_i) begin
        valid_q[q_set] <= 1'b1;
      end
    end
  end

  // compare on registered values
  assign hit_o = valid_bit_q && (tag_q == q_key);

endmodule

/* source/icache_top.sv */
`timescale 1ns/100ps

module icache_top import icache_pkg::*; #(
  parameter int LINE_WORDS = icache_pkg::LINE_WORDS,
  parameter int SETS       = icache_pkg::SETS
) (
  input  logic            clk,
  input  logic            rst,
  // fetch side
  input  logic            fetch_valid_i,
  input  logic [XLEN-1:0] fetch_addr_i,
  output logic            fetch_ready_o,
  output logic            rdata_valid_o,
  output logic [XLEN-1:0] rdata_o,
  // memory side
  output logic            mem_arvalid_o,
  output logic [XLEN-1:0] mem_addr_o,
  output logic [7:0]      mem_len_o,
  input  logic            mem_rvalid_i,
  input  logic [XLEN-1:0] mem_rdata_i
);

  // controller <-> stores
  fetch_addr_u        lookup_addr;
  logic               hit;
  logic               tag_write;
  logic [XLEN-1:0]    line_word;

  // controller <-> memory reader
  logic               start_refill;
  logic               start_uncached;
  logic [XLEN-1:0]    req_addr;
  logic               refill_done;
  logic               uncached_done;
  logic [XLEN-1:0]    uncached_word;

  // refill beats into the data store
  logic               beat_valid;
  logic [BEAT_W-1:0]  beat_index;
  logic [XLEN-1:0]    beat_data;
  logic [INDEX_W-1:0] line_index;

  icache_ctrl icache_ctrl_inst (
    .clk              (clk),
    .rst              (rst),
    .fetch_valid_i    (fetch_valid_i),
    .fetch_addr_i     (fetch_addr_i),
    .fetch_ready_o    (fetch_ready_o),
    .rdata_valid_o    (rdata_valid_o),
    .rdata_o          (rdata_o),
    .hit_i            (hit),
    .line_word_i      (line_word),
    .refill_done_i    (refill_done),
    .uncached_done_i  (uncached_done),
    .uncached_word_i  (uncached_word),
    .lookup_addr_o    (lookup_addr),
    .tag_write_o      (tag_write),
    .start_refill_o   (start_refill),
    .start_uncached_o (start_uncached),
    .req_addr_o       (req_addr)
  );

  icache_tag_store #(
    .SETS (SETS)
  ) icache_tag_store_inst (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_i (lookup_addr),
    .wr_i      (tag_write),
    .hit_o     (hit)
  );

  icache_data_store #(
    .LINE_WORDS (LINE_WORDS),
    .SETS       (SETS)
  ) icache_data_store_inst (
    .clk        (clk),
    .rd_addr_i  (lookup_addr),
    .wr_i       (beat_valid),
    .wr_index_i (line_index),
    .wr_word_i  (beat_index),
    .wr_data_i  (beat_data),
    .rd_data_o  (line_word)
  );

  mem_reader mem_reader_inst (
    .clk              (clk),
    .rst              (rst),
    .start_refill_i   (start_refill),
    .start_uncached_i (start_uncached),
    .req_addr_i       (req_addr),
    .mem_arvalid_o    (mem_arvalid_o),
    .mem_addr_o       (mem_addr_o),
    .mem_len_o        (mem_len_o),
    .mem_rvalid_i     (mem_rvalid_i),
    .mem_rdata_i      (mem_rdata_i),
    .beat_valid_o     (beat_valid),
    .beat_index_o     (beat_index),
    .beat_data_o      (beat_data),
    .line_index_o     (line_index),
    .refill_done_o    (refill_done),
    .uncached_done_o  (uncached_done),
    .uncached_word_o  (uncached_word)
  );

endmodule

/* source/mem_reader.sv */
`timescale 1ns/100ps

module mem_reader import icache_pkg::*; (
  input  logic               clk,
  input  logic               rst,
  // request from the controller
  input  logic               start_refill_i,
  input  logic               start_uncached_i,
  input  logic [XLEN-1:0]    req_addr_i,
  // memory read port
  output logic               mem_arvalid_o,
  output logic [XLEN-1:0]    mem_addr_o,
  output logic [7:0]         mem_len_o,
  input  logic               mem_rvalid_i,
  input  logic [XLEN-1:0]    mem_rdata_i,
  // refill beats toward the data store
  output logic               beat_valid_o,
  output logic [BEAT_W-1:0]  beat_index_o,
  output logic [XLEN-1:0]    beat_data_o,
  output logic [INDEX_W-1:0] line_index_o,
  // completion
  output logic               refill_done_o,
  output logic               uncached_done_o,
  output logic [XLEN-1:0]    uncached_word_o
);

  logic              arvalid_q;
  logic [XLEN-1:0]   addr_q;
  logic [7:0]        len_q;
  logic              refill_q;
  logic [BEAT_W-1:0] beat_cnt_q;
  logic              done_q;
  logic [XLEN-1:0]   word_q;
  logic              start;
  logic              beat;
  logic              last_beat;

  assign start = start_refill_i || start_uncached_i;

  // one beat per cycle with valid on both sides
  assign beat      = arvalid_q && mem_rvalid_i;
  assign last_beat = (beat_cnt_q == len_q[BEAT_W-1:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      arvalid_q  <= 1'b0;
      refill_q   <= 1'b0;
      beat_cnt_q <= '0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start) begin
        arvalid_q  <= 1'b1;
        refill_q   <= start_refill_i;
        beat_cnt_q <= '0;
      end else if (beat) begin
        // counter stalls while memory withholds rvalid
        beat_cnt_q <= beat_cnt_q + 1'b1;
        if (last_beat) begin
          // request drops the cycle after the last beat
          arvalid_q <= 1'b0;
          done_q    <= refill_q;
        end
      end
    end
  end

  // address and length held for the whole request
  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= req_addr_i;
      // full line burst or single word
      len_q  <= start_refill_i ? 8'(LINE_WORDS - 1) : 8'd0;
    end
    if (beat && !refill_q) begin
      word_q <= mem_rdata_i;
    end
  end

  assign mem_arvalid_o = arvalid_q;
  assign mem_addr_o    = addr_q;
  assign mem_len_o     = len_q;

  // refill beats only
  assign beat_valid_o = beat && refill_q;
  assign beat_index_o = beat_cnt_q;
  assign beat_data_o  = mem_rdata_i;
  assign line_index_o = addr_q[OFFSET_W +: INDEX_W];

  assign refill_done_o = done_q;

  // single beat seen in its own cycle, held after
  assign uncached_done_o = beat && !refill_q;
  assign uncached_word_o = uncached_done_o ? mem_rdata_i : word_q;

endmodule

/* src.f */
source/icache_pkg.sv
source/icache_ctrl.sv
source/icache_tag_store.sv
source/icache_data_store.sv
source/mem_reader.sv
source/icache_top.sv
tests/icache_asserts.sv
tests/icache_tb.sv

/* tests/icache_asserts.sv */
`timescale 1ns/100ps

module icache_asserts import icache_pkg::*; (
  input logic            clk,
  input logic            rst,
  input logic            fetch_ready_i,
  input logic            rdata_valid_i,
  input logic            mem_arvalid_i,
  input logic [XLEN-1:0] mem_addr_i
);

  // valid is a one-cycle pulse
  valid_single_pulse: assert property (
    @(posedge clk) disable iff (rst) rdata_valid_i |=> !rdata_valid_i
  ) else $error("rdata_valid_o stayed high for two cycles");

  // no memory request open while idle
  idle_bus_quiet: assert property (
    @(posedge clk) disable iff (rst) fetch_ready_i |-> !mem_arvalid_i
  ) else $error("mem_arvalid_o high while fetch_ready_o is high");

  // address held for the whole request
  addr_held: assert property (
    @(posedge clk) disable iff (rst)
      (mem_arvalid_i && $past(mem_arvalid_i)) |-> $stable(mem_addr_i)
  ) else $error("mem_addr_o changed during an open request");

endmodule

bind icache_top icache_asserts icache_asserts_inst (
  .clk           (clk),
  .rst           (rst),
  .fetch_ready_i (fetch_ready_o),
  .rdata_valid_i (rdata_valid_o),
  .mem_arvalid_i (mem_arvalid_o),
  .mem_addr_i    (mem_addr_o)
);

/* tests/icache_cases.txt */
// columns: case number, fetch address, expected word, expected beats (hex), action
// action 1 applies a reset before the fetch; case number 0 ends the table
01 00001040 5a5a1040 10 0
02 0000107c 5a5a107c 00 0
03 00001040 5a5a1040 00 0
04 10000040 4a5a0040 01 0
05 10000040 4a5a0040 01 0
06 1ffffff0 45a5fff0 01 0
07 00003048 5a5a3048 10 0
08 00001050 5a5a1050 10 0
09 00003040 5a5a3040 10 0
0a 00001040 5a5a1040 10 0
0b 0000105c 5a5a105c 00 0
0c 20000100 7a5a0100 10 0
0d 2000013c 7a5a013c 00 0
0e 0ffffffc 55a5fffc 10 0
0f 0fffffc0 55a5ffc0 00 0
10 00001040 5a5a1040 10 1
11 20000104 7a5a0104 10 0
12 00001044 5a5a1044 00 0
13 10000040 4a5a0040 01 0
14 20000100 7a5a0100 00 0
15 00003040 5a5a3040 10 0
00 00000000 00000000 00 0

/* tests/icache_tb.sv */
`timescale 1ns/100ps

module icache_tb import icache_pkg::*; ();

  localparam int CLK_PERIOD      = 100;
  localparam int RESET_CYCLES    = 5;
  localparam int CYCLES_PER_CASE = 200;
  // case table columns number, address, word, beats, action
  localparam int MAX_CASES       = 64;
  localparam int CASE_COLS       = 5;

  // dut inputs start in a known state
  logic            clk           = 1'b0;
  logic            rst           = 1'b1;
  logic            fetch_valid_i = 1'b0;
  logic [XLEN-1:0] fetch_addr_i  = '0;
  logic            mem_rvalid_i  = 1'b0;
  logic [XLEN-1:0] mem_rdata_i   = '0;

  logic            fetch_ready_o;
  logic            rdata_valid_o;
  logic [XLEN-1:0] rdata_o;
  logic            mem_arvalid_o;
  logic [XLEN-1:0] mem_addr_o;
  logic [7:0]      mem_len_o;

  logic [XLEN-1:0] case_mem [MAX_CASES*CASE_COLS];
  int              n_cases    = 0;
  // beats over the whole run, and within the open request
  int              beat_total = 0;
  int              req_beats  = 0;
  integer          seed       = 32'h6f6764b0;

  icache_top icache_top_inst (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .fetch_addr_i  (fetch_addr_i),
    .fetch_ready_o (fetch_ready_o),
    .rdata_valid_o (rdata_valid_o),
    .rdata_o       (rdata_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_addr_o    (mem_addr_o),
    .mem_len_o     (mem_len_o),
    .mem_rvalid_i  (mem_rvalid_i),
    .mem_rdata_i   (mem_rdata_i)
  );

  always begin
    #(CLK_PERIOD / 2) clk = ~clk;
  end

  // memory contents follow the address
  function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
    return addr ^ 32'h5a5a_0000;
  endfunction

  // memory model, random rvalid, data for the next beat of the request
  always @(posedge clk) begin : mem_model
    int              beats_now;
    logic [XLEN-1:0] rnd;
    if (rst) begin
      mem_rvalid_i <= 1'b0;
      req_beats    <= 0;
    end else if (mem_arvalid_o) begin
      beats_now = req_beats;
      if (mem_rvalid_i) begin
        // a beat is taken on this edge
        beats_now  = req_beats + 1;
        beat_total <= beat_total + 1;
      end
      req_beats <= beats_now;
      if (beats_now <= int'(mem_len_o)) begin
        rnd = $random(seed);
        mem_rvalid_i <= rnd[0];
        mem_rdata_i  <= mem_word(mem_addr_o + (32'(beats_now) << 2));
      end else begin
        mem_rvalid_i <= 1'b0;
      end
    end else begin
      mem_rvalid_i <= 1'b0;
      req_beats    <= 0;
    end
  end

  task automatic check_value(input string name, input logic [XLEN-1:0] expected,
                             input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
      $display("=== FAIL ===");
      $fatal(1, "value check failed in %s", name);
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst           <= 1'b1;
    fetch_valid_i <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic run_case(input int idx);
    logic [XLEN-1:0] case_no;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] exp_word;
    logic [XLEN-1:0] exp_beats;
    logic [XLEN-1:0] action;
    logic [XLEN-1:0] exp_addr;
    int              start_beats;
    int              wait_cycles;
    string           name;
    case_no   = case_mem[idx*CASE_COLS];
    addr      = case_mem[idx*CASE_COLS+1];
    exp_word  = case_mem[idx*CASE_COLS+2];
    exp_beats = case_mem[idx*CASE_COLS+3];
    action    = case_mem[idx*CASE_COLS+4];
    name      = $sformatf("case %0h", case_no);
    // burst starts at the line base, a single read at the word
    if (exp_beats == 32'd1) begin
      exp_addr = addr & 32'hffff_fffc;
    end else begin
      exp_addr = addr & 32'hffff_ffc0;
    end
    if (action == 32'd1) begin
      apply_reset();
    end
    @(posedge clk);
    fetch_valid_i <= 1'b1;
    fetch_addr_i  <= addr;
    // request held until the cache is idle
    @(negedge clk);
    while (!fetch_ready_o) begin
      @(negedge clk);
    end
    start_beats = beat_total;
    // accepted on this edge
    @(posedge clk);
    fetch_valid_i <= 1'b0;
    wait_cycles = 0;
    do begin
      @(negedge clk);
      wait_cycles++;
      // request fields while the read is open
      if (mem_arvalid_o) begin
        check_value({name, " mem_len"}, exp_beats - 32'd1, 32'(mem_len_o));
        check_value({name, " mem_addr"}, exp_addr, mem_addr_o);
      end
    end while (!rdata_valid_o);
    check_value({name, " word"}, exp_word, rdata_o);
    check_value({name, " beats"}, exp_beats, 32'(beat_total - start_beats));
    // hits answer two cycles after the accept cycle
    if (exp_beats == 32'd0) begin
      check_value({name, " hit latency"}, 32'd2, 32'(wait_cycles));
    end
  endtask

  initial begin : case_player
    int idx;
    $readmemh("tests/icache_cases.txt", case_mem);
    // case number zero ends the table
    idx = 0;
    while (idx < MAX_CASES && case_mem[idx*CASE_COLS] != '0) begin
      idx++;
    end
    if (idx == 0) begin
      $display("no cases found in tests/icache_cases.txt");
      $display("=== FAIL ===");
      $fatal(1, "empty case table");
    end
    n_cases = idx;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < n_cases; i++) begin
      run_case(i);
    end
    $display("ran %0d cases", n_cases);
    $display("=== PASS ===");
    $finish;
  end

  // run limit scales with the case count
  initial begin : watchdog
    longint limit_cycles;
    wait (n_cases != 0);
    limit_cycles = longint'(n_cases) * CYCLES_PER_CASE + RESET_CYCLES;
    #(limit_cycles * CLK_PERIOD);
    $display("timeout: the cases did not finish within %0d clock cycles", limit_cycles);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

endmodule
